// File: fc_pkg.sv
// fc dot-product engine shared widths, beat opcodes and stage payload structs
package fc_pkg;

  ////////////////////
  // widths
  localparam int DATA_W    = 8;    // feature, weight, bias
  localparam int PROD_W    = 16;
  localparam int ACC_W     = 28;
  localparam int NUM_LANES = 4;
  localparam int Q_MAX     = 127;  // saturation value of a result byte

  ////////////////////
  // beat opcode, bit 0 clears the partial sum, bit 1 emits a result
  typedef enum logic [1:0] {
    BEAT_MID   = 2'b00,
    BEAT_FIRST = 2'b01,
    BEAT_LAST  = 2'b10,
    BEAT_ONLY  = 2'b11
  } beat_kind_e;

  typedef struct packed {
    beat_kind_e                       kind;
    logic [DATA_W-1:0]                feat;
    logic [NUM_LANES-1:0][DATA_W-1:0] weight;
    logic [NUM_LANES-1:0][DATA_W-1:0] bias;    // only looked at on emit
  } beat_t;

  typedef struct packed {
    logic                             valid;
    beat_kind_e                       kind;
    logic [NUM_LANES-1:0][DATA_W-1:0] bias;
    logic [NUM_LANES-1:0][PROD_W-1:0] prod;
  } prod_t;

  typedef struct packed {
    logic                            valid;  // emitting beats only
    logic [NUM_LANES-1:0][ACC_W-1:0] sum;
  } acc_vec_t;

  typedef struct packed {
    logic [NUM_LANES-1:0][DATA_W-1:0] lane;
  } result_t;

  function automatic logic kind_clears(beat_kind_e k);
    return (k == BEAT_FIRST) || (k == BEAT_ONLY);
  endfunction

  function automatic logic kind_emits(beat_kind_e k);
    return (k == BEAT_LAST) || (k == BEAT_ONLY);
  endfunction

endpackage

// File: beat_intake.sv
// input four-phase handshake, captures beats and holds off while a result is pending
`timescale 1ns/1ps

module beat_intake import fc_pkg::*; (
  input  logic  clk,
  input  logic  rstn,
  input  logic  in_req,
  input  beat_t in_beat,
  output logic  in_ack,
  input  logic  out_busy,
  output logic  st_valid,
  output beat_t st_beat
);

  typedef enum logic {WAIT_REQ, WAIT_DROP} intake_state_e;

  intake_state_e state;
  logic          last_pend;  // emitting beat inside the pipe
  logic          busy_q;
  logic          can_take;

  assign can_take = in_req && !last_pend && !out_busy;

  ////////////////////
  // handshake FSM
  always_ff @(posedge clk) begin
    if (!rstn) begin
      state     <= WAIT_REQ;
      in_ack    <= 1'b0;
      st_valid  <= 1'b0;
      last_pend <= 1'b0;
      busy_q    <= 1'b0;
    end else begin
      st_valid <= 1'b0;  // one cycle per beat
      busy_q   <= out_busy;
      if (busy_q && !out_busy) last_pend <= 1'b0;  // result delivered
      case (state)
        WAIT_REQ: begin
          if (can_take) begin
            in_ack   <= 1'b1;
            st_valid <= 1'b1;
            state    <= WAIT_DROP;
            if (kind_emits(in_beat.kind)) last_pend <= 1'b1;
          end
        end
        WAIT_DROP: begin
          if (!in_req) begin
            in_ack <= 1'b0;
            state  <= WAIT_REQ;
          end
        end
        default: state <= WAIT_REQ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == WAIT_REQ && can_take) st_beat <= in_beat;
  end

  // ack only answers a request seen on the previous edge
  a_ack_needs_req: assert property (@(posedge clk) disable iff (!rstn)
    $rose(in_ack) |-> $past(in_req));

  a_stage_one_cycle: assert property (@(posedge clk) disable iff (!rstn)
    st_valid |=> !st_valid);

endmodule

// File: mult_pipe.sv
// signed 8x8 multiplier, sign-magnitude with a registered partial-product adder tree
`timescale 1ns/1ps

module mult_pipe import fc_pkg::*; (
  input  logic              clk,
  input  logic              rstn,
  input  logic              in_valid,
  input  logic [DATA_W-1:0] a,
  input  logic [DATA_W-1:0] b,
  output logic              out_valid,
  output logic [PROD_W-1:0] prod
);

  logic [DATA_W-1:0] a_mag;
  logic [DATA_W-1:0] b_mag;
  logic [DATA_W-1:0] pp [DATA_W];

  logic              v_s1, v_s2, v_s3;
  logic              sgn_s1, sgn_s2, sgn_s3;
  logic [DATA_W-1:0] pp_s1 [DATA_W];  // eight rows, weight 2^k
  logic [9:0]        sum_s2 [4];      // row pairs, weight 4^k
  logic [11:0]       sum_s3 [2];      // pairs of pairs, weight 16^k
  logic [PROD_W-1:0] mag;

  ////////////////////
  // stage 1, magnitudes and partial products
  assign a_mag = a[DATA_W-1] ? (~a + 1'b1) : a;
  assign b_mag = b[DATA_W-1] ? (~b + 1'b1) : b;

  always_comb begin
    for (int k = 0; k < DATA_W; k++) begin
      pp[k] = b_mag[k] ? a_mag : '0;
    end
  end

  always_ff @(posedge clk) begin
    for (int k = 0; k < DATA_W; k++) begin
      pp_s1[k] <= pp[k];
    end
    sgn_s1 <= a[DATA_W-1] ^ b[DATA_W-1];
  end

  ////////////////////
  // stage 2, adjacent rows
  always_ff @(posedge clk) begin
    for (int k = 0; k < 4; k++) begin
      sum_s2[k] <= {2'b00, pp_s1[2*k]} + {1'b0, pp_s1[2*k+1], 1'b0};
    end
    sgn_s2 <= sgn_s1;
  end

  ////////////////////
  // stage 3, pairs of pairs
  always_ff @(posedge clk) begin
    for (int k = 0; k < 2; k++) begin
      sum_s3[k] <= {2'b00, sum_s2[2*k]} + {sum_s2[2*k+1], 2'b00};
    end
    sgn_s3 <= sgn_s2;
  end

  ////////////////////
  // stage 4, last add and sign restore
  assign mag = {4'b0000, sum_s3[0]} + {sum_s3[1], 4'b0000};

  always_ff @(posedge clk) begin
    prod <= sgn_s3 ? (~mag + 1'b1) : mag;  // zero stays zero
  end

  // valid bits walk alongside the data
  always_ff @(posedge clk) begin
    if (!rstn) begin
      v_s1      <= 1'b0;
      v_s2      <= 1'b0;
      v_s3      <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      v_s1      <= in_valid;
      v_s2      <= v_s1;
      v_s3      <= v_s2;
      out_valid <= v_s3;
    end
  end

  a_latency_four: assert property (@(posedge clk) disable iff (!rstn)
    out_valid == $past(in_valid, 4));

endmodule

// File: psum_accum.sv
// per-lane partial-sum accumulator with first-beat clear and bias add on the last beat
`timescale 1ns/1ps

module psum_accum import fc_pkg::*; #(
  parameter int LANES = NUM_LANES
) (
  input  logic     clk,
  input  logic     rstn,
  input  prod_t    p_in,
  output acc_vec_t acc_out
);

  localparam int MULT_DEPTH = 4;  // matches the multiplier adder tree

  // kind and bias enter with the stage 0 beat and are delayed here
  // so that they line up with the products
  beat_kind_e                       kind_sh [MULT_DEPTH];
  logic [NUM_LANES-1:0][DATA_W-1:0] bias_sh [MULT_DEPTH];

  logic [ACC_W-1:0]                psum     [LANES];
  logic [ACC_W-1:0]                psum_nxt [LANES];
  logic [ACC_W-1:0]                bias_ext [LANES];
  logic [NUM_LANES-1:0][ACC_W-1:0] acc_sum;
  logic                            acc_valid;
  beat_kind_e                      kind_al;

  assign kind_al = kind_sh[MULT_DEPTH-1];

  always_ff @(posedge clk) begin
    kind_sh[0] <= p_in.kind;
    bias_sh[0] <= p_in.bias;
    for (int s = 1; s < MULT_DEPTH; s++) begin
      kind_sh[s] <= kind_sh[s-1];
      bias_sh[s] <= bias_sh[s-1];
    end
  end

  ////////////////////
  // accumulate
  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      psum_nxt[i] = {{(ACC_W-PROD_W){p_in.prod[i][PROD_W-1]}}, p_in.prod[i]};
      if (!kind_clears(kind_al)) psum_nxt[i] = psum_nxt[i] + psum[i];
      bias_ext[i] = {{(ACC_W-DATA_W){bias_sh[MULT_DEPTH-1][i][DATA_W-1]}},
                     bias_sh[MULT_DEPTH-1][i]};
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      acc_valid <= 1'b0;
      for (int i = 0; i < LANES; i++) psum[i] <= '0;
    end else begin
      acc_valid <= p_in.valid && kind_emits(kind_al);
      if (p_in.valid) begin
        for (int i = 0; i < LANES; i++) psum[i] <= psum_nxt[i];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (p_in.valid) begin
      for (int i = 0; i < LANES; i++) acc_sum[i] <= psum_nxt[i] + bias_ext[i];
    end
  end

  assign acc_out.valid = acc_valid;
  assign acc_out.sum   = acc_sum;

  a_emit_spaced: assert property (@(posedge clk) disable iff (!rstn)
    acc_out.valid |=> !acc_out.valid);

endmodule

// File: requant_out.sv
// ReLU, requantise and saturate each lane, then hold the result for the output handshake
`timescale 1ns/1ps

module requant_out import fc_pkg::*; #(
  parameter int LANES      = NUM_LANES,
  parameter int FRAC_SHIFT = 6
) (
  input  logic     clk,
  input  logic     rstn,
  input  acc_vec_t acc_in,
  input  logic     beat_taken,
  input  logic     beat_emits,
  output logic     out_req,
  input  logic     out_ack,
  output result_t  out_res,
  output logic     out_busy
);

  typedef enum logic [1:0] {EMPTY, REQ, DROP} out_state_e;

  out_state_e       state;
  result_t          q_res;
  logic [ACC_W-1:0] shifted [LANES];

  ////////////////////
  // requantise
  always_comb begin
    q_res = '0;
    for (int i = 0; i < LANES; i++) begin
      shifted[i] = acc_in.sum[i] >> FRAC_SHIFT;
      if (acc_in.sum[i][ACC_W-1]) begin
        q_res.lane[i] = '0;  // relu
      end else if (shifted[i] > ACC_W'(Q_MAX)) begin
        q_res.lane[i] = DATA_W'(Q_MAX);
      end else begin
        q_res.lane[i] = shifted[i][DATA_W-1:0];
      end
    end
  end

  // holding register, only loaded when idle
  always_ff @(posedge clk) begin
    if (state == EMPTY && acc_in.valid) out_res <= q_res;
  end

  ////////////////////
  // output handshake
  always_ff @(posedge clk) begin
    if (!rstn) begin
      state    <= EMPTY;
      out_req  <= 1'b0;
      out_busy <= 1'b0;
    end else begin
      if (beat_taken && beat_emits) out_busy <= 1'b1;
      case (state)
        EMPTY: if (acc_in.valid) begin
          out_req <= 1'b1;
          state   <= REQ;
        end
        REQ: if (out_ack) begin
          out_req <= 1'b0;
          state   <= DROP;
        end
        DROP: if (!out_ack) begin
          out_busy <= 1'b0;  // lets intake take the next beat
          state    <= EMPTY;
        end
        default: state <= EMPTY;
      endcase
    end
  end

  a_res_stable: assert property (@(posedge clk) disable iff (!rstn)
    out_req && $past(out_req) |-> $stable(out_res));

endmodule

// File: fc_core.sv
// top level of the four-lane fully-connected dot-product engine
`timescale 1ns/1ps

module fc_core import fc_pkg::*; #(
  parameter int LANES      = NUM_LANES,
  parameter int FRAC_SHIFT = 6
) (
  input  logic    clk,
  input  logic    rstn,
  input  logic    in_req,
  input  beat_t   in_beat,
  output logic    in_ack,
  output logic    out_req,
  input  logic    out_ack,
  output result_t out_res
);

  logic                             st_valid;
  beat_t                            st_beat;
  logic                             out_busy;
  logic [LANES-1:0]                 lane_valid;
  logic [NUM_LANES-1:0][PROD_W-1:0] lane_prod;
  prod_t                            p_in;
  acc_vec_t                         acc;

  beat_intake u_intake (
    .clk      (clk),
    .rstn     (rstn),
    .in_req   (in_req),
    .in_beat  (in_beat),
    .in_ack   (in_ack),
    .out_busy (out_busy),
    .st_valid (st_valid),
    .st_beat  (st_beat)
  );

  ////////////////////
  // multiplier lanes with the feature broadcast to all
  for (genvar i = 0; i < LANES; i++) begin : g_lane
    mult_pipe u_mult (
      .clk       (clk),
      .rstn      (rstn),
      .in_valid  (st_valid),
      .a         (st_beat.feat),
      .b         (st_beat.weight[i]),
      .out_valid (lane_valid[i]),
      .prod      (lane_prod[i])
    );
  end

  // kind and bias leave at the stage 0 tap and psum_accum delays them
  assign p_in = '{valid: lane_valid[0], kind: st_beat.kind, bias: st_beat.bias,
                  prod: lane_prod};

  psum_accum #(.LANES(LANES)) u_accum (
    .clk     (clk),
    .rstn    (rstn),
    .p_in    (p_in),
    .acc_out (acc)
  );

  requant_out #(.LANES(LANES), .FRAC_SHIFT(FRAC_SHIFT)) u_out (
    .clk        (clk),
    .rstn       (rstn),
    .acc_in     (acc),
    .beat_taken (st_valid),
    .beat_emits (kind_emits(st_beat.kind)),
    .out_req    (out_req),
    .out_ack    (out_ack),
    .out_res    (out_res),
    .out_busy   (out_busy)
  );

endmodule

// File: tb_fc_core.sv
// testbench for the fc dot-product engine with directed and LFSR vector tests
`timescale 1ns/1ps

module tb_fc_core import fc_pkg::*; ();

  localparam int TMO  = 200;  // cycles allowed per wait
  localparam int FRAC = 6;

  logic    clk = 1'b0;
  logic    rstn;
  logic    in_req;
  beat_t   in_beat;
  logic    in_ack;
  logic    out_req;
  logic    out_ack;
  result_t out_res;

  // beats of the vector under test
  logic [DATA_W-1:0]                feat_a [8];
  logic [NUM_LANES-1:0][DATA_W-1:0] w_a    [8];
  logic [NUM_LANES-1:0][DATA_W-1:0] b_a    [8];

  logic [15:0] lfsr = 16'd58;
  int          cycle, ack_cyc, req_cyc;
  int          errors, checks, tests;

  fc_core dut_i (
    .clk     (clk),
    .rstn    (rstn),
    .in_req  (in_req),
    .in_beat (in_beat),
    .in_ack  (in_ack),
    .out_req (out_req),
    .out_ack (out_ack),
    .out_res (out_res)
  );

  always #2 clk = ~clk;
  always @(posedge clk) cycle <= cycle + 1;

  ////////////////////
  // helpers
  task automatic check_val(input logic [31:0] got, input logic [31:0] exp,
                           input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t: %s, got %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic stop_on_timeout(input string what);
    $display("timeout while waiting for %s, simulation stopped", what);
    $display("** FAIL **");
    $finish;
  endtask

  // galois lfsr with taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  function automatic int rand_bits(input int n);
    int v;
    v = 0;
    for (int k = 0; k < n; k++) begin
      v    = (v << 1) | int'(lfsr[0]);  // one step per bit
      lfsr = lfsr_next(lfsr);
    end
    return v;
  endfunction

  function automatic beat_kind_e kind_at(input int j, input int len);
    if (len == 1) return BEAT_ONLY;
    if (j == 0) return BEAT_FIRST;
    if (j == len - 1) return BEAT_LAST;
    return BEAT_MID;
  endfunction

  // reference model of signed dot product, last-beat bias, relu, shift and clamp
  function automatic result_t model_result(input int len);
    result_t r;
    int      acc;
    int      f;
    int      wv;
    for (int i = 0; i < NUM_LANES; i++) begin
      acc = 0;
      for (int j = 0; j < len; j++) begin
        f   = $signed(feat_a[j]);
        wv  = $signed(w_a[j][i]);
        acc = acc + f * wv;
      end
      wv  = $signed(b_a[len-1][i]);
      acc = acc + wv;
      if (acc < 0) r.lane[i] = 8'd0;
      else if ((acc >>> FRAC) > Q_MAX) r.lane[i] = 8'(Q_MAX);
      else r.lane[i] = 8'(acc >>> FRAC);
    end
    return r;
  endfunction

  // w and b hold lanes 3..0
  task automatic set_beat(input int j, input logic [7:0] f, input logic [31:0] w,
                          input logic [31:0] b);
    feat_a[j] = f;
    w_a[j]    = w;
    b_a[j]    = b;
  endtask

  ////////////////////
  // handshake drivers
  task automatic send_beat(input beat_t b);
    int n;
    n       = 0;
    in_beat = b;
    in_req  = 1'b1;
    while (!in_ack) begin
      if (n == TMO) stop_on_timeout("in_ack to rise");
      @(posedge clk);
      #1;
      n++;
    end
    ack_cyc = cycle;
    in_req  = 1'b0;
    n       = 0;
    while (in_ack) begin
      if (n == TMO) stop_on_timeout("in_ack to fall");
      @(posedge clk);
      #1;
      n++;
    end
  endtask

  task automatic send_part(input int lo, input int hi, input int len);
    beat_t b;
    for (int j = lo; j < hi; j++) begin
      b.kind   = kind_at(j, len);
      b.feat   = feat_a[j];
      b.weight = w_a[j];
      b.bias   = b_a[j];
      send_beat(b);
    end
  endtask

  task automatic wait_out_req();
    int n;
    n = 0;
    while (!out_req) begin
      if (n == TMO) stop_on_timeout("out_req to rise");
      @(posedge clk);
      #1;
      n++;
    end
  endtask

  task automatic get_result(input int hold, output result_t res);
    int n;
    wait_out_req();
    req_cyc = cycle;
    res     = out_res;
    repeat (hold) @(posedge clk);  // slow consumer
    if (hold > 0) #1;
    out_ack = 1'b1;
    n       = 0;
    while (out_req) begin
      if (n == TMO) stop_on_timeout("out_req to fall");
      @(posedge clk);
      #1;
      n++;
    end
    out_ack = 1'b0;
  endtask

  task automatic check_lanes(input result_t got, input int len, input string what);
    result_t exp;
    exp = model_result(len);
    for (int i = 0; i < NUM_LANES; i++) begin
      check_val(got.lane[i], exp.lane[i], $sformatf("%s lane %0d", what, i));
    end
  endtask

  task automatic run_vector(input int len, input int hold, input string what);
    result_t got;
    send_part(0, len, len);
    get_result(hold, got);
    check_lanes(got, len, what);
  endtask

  task automatic end_test(input string name, input int err0);
    tests++;
    $display("test %s done, %0d errors", name, errors - err0);
  endtask

  ////////////////////
  // directed tests
  task automatic test_single_beat();
    int      e0;
    result_t got;
    e0 = errors;
    set_beat(0, 8'd16, {8'd4, 8'd20, 8'd12, 8'd8}, 32'd0);
    send_part(0, 1, 1);
    get_result(0, got);
    check_val(req_cyc - ack_cyc, 6, "single beat out_req latency");
    check_val(got, 32'h01050302, "single beat result");  // 64 320 192 128 >> 6
    check_lanes(got, 1, "single beat");
    end_test("single_beat", e0);
  endtask

  task automatic test_vector_clear();
    int e0;
    e0 = errors;
    set_beat(0, 8'd50, {8'd10, 8'd20, 8'd40, 8'd30}, 32'd0);
    set_beat(1, 8'd60, {8'd15, 8'd45, 8'd35, 8'd25}, 32'd0);
    set_beat(2, 8'd40, {8'd40, 8'd30, 8'd20, 8'd10}, 32'd0);
    set_beat(3, 8'd70, {8'd35, 8'd25, 8'd15, 8'd5}, {8'd7, 8'd0, 8'(-2), 8'd3});
    run_vector(4, 0, "first vector");
    // small sums so any leftover would show
    set_beat(0, 8'd10, {8'd9, 8'd8, 8'd7, 8'd6}, 32'd0);
    set_beat(1, 8'd20, {8'd4, 8'd3, 8'd2, 8'd1}, 32'd0);
    set_beat(2, 8'd30, {8'd2, 8'd2, 8'd2, 8'd2}, 32'd0);
    run_vector(3, 0, "second vector");
    end_test("vector_clear", e0);
  endtask

  task automatic test_mixed_signs();
    int      e0;
    result_t got;
    e0 = errors;
    set_beat(0, 8'(-40), {8'd30, 8'(-9), 8'(-50), 8'd50}, 32'd0);
    set_beat(1, 8'd25, {8'd12, 8'd20, 8'd40, 8'(-30)}, 32'd0);
    set_beat(2, 8'd60, {8'(-3), 8'd4, 8'd20, 8'(-10)}, {8'(-20), 8'd5, 8'(-7), 8'd9});
    send_part(0, 3, 3);
    get_result(0, got);
    check_val(got.lane[0], 8'd0, "negative lane clipped");
    check_lanes(got, 3, "mixed signs");
    end_test("mixed_signs", e0);
  endtask

  task automatic test_saturation_bias();
    int      e0;
    result_t got;
    e0 = errors;
    set_beat(0, 8'd100, {8'd50, 8'(-128), 8'd127, 8'd100}, 32'd0);
    send_part(0, 1, 1);
    get_result(0, got);
    check_val(got, 32'h4E007F7F, "saturation result");
    check_lanes(got, 1, "saturation");
    // products sit next to 64 and the bias moves them across
    set_beat(0, 8'd8, {8'd7, 8'd7, 8'd8, 8'd8}, {8'd8, 8'd0, 8'(-1), 8'd0});
    send_part(0, 1, 1);
    get_result(0, got);
    check_val(got, 32'h01000001, "bias threshold result");
    check_lanes(got, 1, "bias threshold");
    end_test("saturation_bias", e0);
  endtask

  task automatic test_back_pressure();
    int      e0;
    result_t got;
    result_t exp_a;
    result_t snap;
    e0 = errors;
    set_beat(0, 8'd33, {8'd11, 8'd22, 8'd33, 8'd44}, 32'd0);
    set_beat(1, 8'(-17), {8'd5, 8'(-6), 8'd7, 8'(-8)}, {8'd1, 8'd2, 8'd3, 8'd4});
    send_part(0, 2, 2);
    exp_a = model_result(2);
    set_beat(0, 8'd21, {8'd13, 8'd12, 8'd11, 8'd10}, 32'd0);
    set_beat(1, 8'd19, {8'd9, 8'd8, 8'd7, 8'd6}, {8'd0, 8'(-5), 8'd5, 8'd0});
    wait_out_req();
    snap = out_res;
    fork
      get_result(20, got);
      send_part(0, 1, 2);  // offered while the result is held
      begin
        repeat (20) begin
          @(posedge clk);
          #1;
          check_val(in_ack, 1'b0, "in_ack during back-pressure");
          check_val(out_req, 1'b1, "out_req during back-pressure");
          check_val(out_res, snap, "out_res during back-pressure");
        end
      end
    join
    for (int i = 0; i < NUM_LANES; i++) begin
      check_val(got.lane[i], exp_a.lane[i], $sformatf("held vector lane %0d", i));
    end
    send_part(1, 2, 2);
    get_result(0, got);
    check_lanes(got, 2, "vector after back-pressure");
    end_test("back_pressure", e0);
  endtask

  task automatic test_random();
    int e0;
    int len;
    int hold;
    e0 = errors;
    for (int v = 0; v < 20; v++) begin
      len = rand_bits(3) % 6 + 1;
      for (int j = 0; j < len; j++) begin
        feat_a[j] = 8'(rand_bits(8));
        for (int i = 0; i < NUM_LANES; i++) begin
          w_a[j][i] = 8'(rand_bits(5) - 16);  // keeps many sums off the clamps
          b_a[j][i] = 8'(rand_bits(8));
        end
      end
      hold = rand_bits(2);
      run_vector(len, hold, $sformatf("random vector %0d", v));
    end
    end_test("random", e0);
  endtask

  initial begin
    rstn    = 1'b0;
    in_req  = 1'b0;
    in_beat = '0;
    out_ack = 1'b0;
    repeat (16) @(posedge clk);
    #1;
    rstn = 1'b1;
    repeat (2) @(posedge clk);
    #1;
    test_single_beat();
    test_vector_clear();
    test_mixed_signs();
    test_saturation_bias();
    test_back_pressure();
    test_random();
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// File: list.f
fc_pkg.sv
beat_intake.sv
mult_pipe.sv
psum_accum.sv
requant_out.sv
fc_core.sv
tb_fc_core.sv

// File: Makefile
SIM     := verilator
FLAGS   := --binary --timing --assert -Wno-fatal
TOP     := tb_fc_core
FLIST   := list.f
OBJ_DIR := obj_dir
BIN     := $(OBJ_DIR)/V$(TOP)
LOG     := sim.log
SRCS    := $(shell cat $(FLIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -qF '** FAIL **' $(LOG); then \
	  echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
